// ==== cpu_pkg.sv ====
// ======================================================================
// shared types, encodings, stage payloads and reset constants for the core
// ======================================================================
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00, J     = 6'h02, BEQ = 6'h04, ADDIU = 6'h09, ORI  = 6'h0d,
    LUI   = 6'h0f, LW    = 6'h23, SW  = 6'h2b, HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    ADDU = 6'h21, SUBU = 6'h23, AND = 6'h24, OR = 6'h25, SLT = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASSB
  } aluop_t;

  typedef enum logic {SRC_REG, SRC_IMM} alusrc_t;
  typedef enum logic {DST_RD, DST_RT} regdst_t;
  typedef enum logic {WB_ALU, WB_MEM} wbsel_t;
  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extend_t;
  typedef enum logic [1:0] {PC_NEXT, PC_JUMP, PC_BRANCH} pcsrc_t;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdsel_t;

  // all-zero value is an inactive bubble
  typedef struct packed {
    logic    wen;
    logic    dren;
    logic    dwen;
    logic    halt;
    aluop_t  alu_op;
    alusrc_t alu_src;
    regdst_t reg_dst;
    wbsel_t  wb_sel;
    extend_t extend;
    logic    branch;
    logic    jump;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pc4;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc4;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    result;
    logic     zero;
    word_t    store;
    word_t    br_target;
    regbits_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic     wen;
    wbsel_t   wb_sel;
    logic     halt;
    word_t    result;
    word_t    load;
    regbits_t dest;
  } mem_wb_t;

  localparam word_t PC_INIT  = 32'h0000_0000;
  localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

// ==== cpu_ifs.sv ====
// ======================================================================
// hazard_if and forward_if with their modports
// ======================================================================
interface hazard_if import cpu_pkg::*; ();
  // observed pipeline state
  logic     ihit;
  logic     dhit;
  logic     idex_dren;
  regbits_t idex_rt;
  regbits_t ifid_rs;
  regbits_t ifid_rt;
  logic     ifid_jump;
  logic     exmem_taken;
  logic     exmem_req;
  logic     memwb_halt;
  // stall and flush controls
  logic     pc_en;
  pcsrc_t   pc_src;
  logic     ifid_en, ifid_flush;
  logic     idex_en, idex_flush;
  logic     exmem_en, exmem_flush;
  logic     memwb_en, memwb_flush;

  modport dp (
    output ihit, dhit, idex_dren, idex_rt, ifid_rs, ifid_rt, ifid_jump,
           exmem_taken, exmem_req, memwb_halt,
    input  pc_en, pc_src, ifid_en, ifid_flush, idex_en, idex_flush,
           exmem_en, exmem_flush, memwb_en, memwb_flush
  );

  modport hu (
    input  ihit, dhit, idex_dren, idex_rt, ifid_rs, ifid_rt, ifid_jump,
           exmem_taken, exmem_req, memwb_halt,
    output pc_en, pc_src, ifid_en, ifid_flush, idex_en, idex_flush,
           exmem_en, exmem_flush, memwb_en, memwb_flush
  );
endinterface

interface forward_if import cpu_pkg::*; ();
  regbits_t idex_rs, idex_rt;
  regbits_t exmem_dest, memwb_dest;
  logic     exmem_wen, memwb_wen;
  fwdsel_t  fwd_a, fwd_b, fwd_store;

  modport dp (
    output idex_rs, idex_rt, exmem_dest, memwb_dest, exmem_wen, memwb_wen,
    input  fwd_a, fwd_b, fwd_store
  );

  modport fu (
    input  idex_rs, idex_rt, exmem_dest, memwb_dest, exmem_wen, memwb_wen,
    output fwd_a, fwd_b, fwd_store
  );
endinterface

// ==== alu.sv ====
// ======================================================================
// combinational ALU with zero flag
// ======================================================================
module alu import cpu_pkg::*; (
  input  word_t  port_a,
  input  word_t  port_b,
  input  aluop_t alu_op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (alu_op)
      ALU_ADD:   result = port_a + port_b;
      ALU_SUB:   result = port_a - port_b;
      ALU_AND:   result = port_a & port_b;
      ALU_OR:    result = port_a | port_b;
      // signed compare
      ALU_SLT:   result = ($signed(port_a) < $signed(port_b)) ? 32'd1 : 32'd0;
      ALU_PASSB: result = port_b;
      default:   result = '0;
    endcase
  end

  // beq uses sub, so zero means equal operands
  assign zero = (result == '0);

endmodule

// ==== register_file.sv ====
// ======================================================================
// 32x32 register file, two read ports and one write port
// ======================================================================
module register_file import cpu_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-before-read bypass
  assign rdat1 = (wen && wsel != '0 && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wen && wsel != '0 && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// ==== control_unit.sv ====
// ======================================================================
// instruction decode into ID stage control fields
// ======================================================================
module control_unit import cpu_pkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  always_comb begin
    // unknown encodings fall out as a bubble
    ctrl = '0;
    case (opcode)
      RTYPE: begin
        ctrl.reg_dst = DST_RD;
        ctrl.wen = 1'b1;
        case (funct)
          ADDU:    ctrl.alu_op = ALU_ADD;
          SUBU:    ctrl.alu_op = ALU_SUB;
          AND:     ctrl.alu_op = ALU_AND;
          OR:      ctrl.alu_op = ALU_OR;
          SLT:     ctrl.alu_op = ALU_SLT;
          default: ctrl.wen = 1'b0;
        endcase
      end
      ADDIU, ORI, LUI, LW: begin
        ctrl.wen = 1'b1;
        ctrl.reg_dst = DST_RT;
        ctrl.alu_src = SRC_IMM;
        ctrl.extend = (opcode == ORI) ? EXT_ZERO :
                      (opcode == LUI) ? EXT_UPPER : EXT_SIGN;
        ctrl.alu_op = (opcode == ORI) ? ALU_OR :
                      (opcode == LUI) ? ALU_PASSB : ALU_ADD;
        ctrl.dren = (opcode == LW);
        ctrl.wb_sel = (opcode == LW) ? WB_MEM : WB_ALU;
      end
      SW: begin
        ctrl.dwen = 1'b1;
        ctrl.alu_src = SRC_IMM;
        ctrl.extend = EXT_SIGN;
      end
      BEQ: begin
        // compare by subtraction, offset sign extended
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
        ctrl.extend = EXT_SIGN;
      end
      J:       ctrl.jump = 1'b1;
      HALT:    ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== pipe_reg.sv ====
// ======================================================================
// pipeline stage register with enable and flush
// ======================================================================
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     en,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush wins over enable and leaves a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// ==== forward_unit.sv ====
// ======================================================================
// operand and store-data forwarding select
// ======================================================================
module forward_unit import cpu_pkg::*; (
  forward_if.fu fif
);

  // youngest producer wins, register 0 never forwards
  function automatic fwdsel_t pick(input regbits_t src, input regbits_t mem_dest,
                                   input logic mem_wen, input regbits_t wb_dest,
                                   input logic wb_wen);
    if (mem_wen && mem_dest != '0 && mem_dest == src) begin
      return FWD_MEM;
    end else if (wb_wen && wb_dest != '0 && wb_dest == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign fif.fwd_a = pick(fif.idex_rs, fif.exmem_dest, fif.exmem_wen,
                          fif.memwb_dest, fif.memwb_wen);
  assign fif.fwd_b = pick(fif.idex_rt, fif.exmem_dest, fif.exmem_wen,
                          fif.memwb_dest, fif.memwb_wen);
  // sw data follows rt even when port b takes the immediate
  assign fif.fwd_store = pick(fif.idex_rt, fif.exmem_dest, fif.exmem_wen,
                              fif.memwb_dest, fif.memwb_wen);

endmodule

// ==== hazard_unit.sv ====
// ======================================================================
// per-stage enables, flushes and PC source
// ======================================================================
module hazard_unit import cpu_pkg::*; (
  hazard_if.hu hif
);

  logic load_use;

  assign load_use = hif.idex_dren &&
                    (hif.idex_rt == hif.ifid_rs || hif.idex_rt == hif.ifid_rt);

  always_comb begin
    hif.pc_en = 1'b1;
    hif.pc_src = PC_NEXT;
    hif.ifid_en = 1'b1;
    hif.idex_en = 1'b1;
    hif.exmem_en = 1'b1;
    hif.memwb_en = 1'b1;
    hif.ifid_flush = 1'b0;
    hif.idex_flush = 1'b0;
    hif.exmem_flush = 1'b0;
    // nothing behind writeback to squash
    hif.memwb_flush = 1'b0;

    // halted or waiting on data memory: freeze everything
    if (hif.memwb_halt || (hif.exmem_req && !hif.dhit)) begin
      hif.pc_en = 1'b0;
      hif.ifid_en = 1'b0;
      hif.idex_en = 1'b0;
      hif.exmem_en = 1'b0;
      hif.memwb_en = 1'b0;
    end else if (hif.exmem_taken) begin
      hif.pc_src = PC_BRANCH;
      hif.ifid_flush = 1'b1;
      hif.idex_flush = 1'b1;
      hif.exmem_flush = 1'b1;
    end else if (load_use || !hif.ihit) begin
      // hold fetch and decode, bubble into EX
      hif.pc_en = hif.ifid_jump && !load_use;
      hif.pc_src = (hif.ifid_jump && !load_use) ? PC_JUMP : PC_NEXT;
      hif.ifid_en = 1'b0;
      hif.ifid_flush = hif.ifid_jump && !load_use;
      hif.idex_flush = load_use || !hif.ifid_jump;
    end else if (hif.ifid_jump) begin
      hif.pc_src = PC_JUMP;
      hif.ifid_flush = 1'b1;
    end
  end

endmodule

// ==== datapath.sv ====
// ======================================================================
// pipelined core top: PC, extender, muxes and stage instances
// ======================================================================
module datapath import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t imem_load,
  input  logic  ihit,
  input  word_t dmem_load,
  input  logic  dhit,
  output word_t imem_addr,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  output logic  halt
);

  word_t   pc, pc4, next_pc, jump_target;
  word_t   rdat1, rdat2, imm_ext, wdat;
  word_t   operand_a, operand_b, port_b, alu_result;
  logic    alu_zero;
  ctrl_t   id_ctrl;
  if_id_t  if_id_d, if_id_q;
  id_ex_t  id_ex_d, id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  mem_wb_t mem_wb_d, mem_wb_q;

  hazard_if  hif ();
  forward_if fif ();

  function automatic word_t fwd_mux(input fwdsel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // fetch
  assign pc4 = pc + 32'd4;
  assign imem_addr = pc;

  always_comb begin
    case (hif.pc_src)
      PC_JUMP:   next_pc = jump_target;
      PC_BRANCH: next_pc = ex_mem_q.br_target;
      default:   next_pc = pc4;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (hif.pc_en) begin
      pc <= next_pc;
    end
  end

  always_comb begin
    if_id_d.instr = imem_load;
    if_id_d.pc4 = pc4;
  end

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .CLK, .nRST, .en(hif.ifid_en), .flush(hif.ifid_flush), .d(if_id_d), .q(if_id_q)
  );

  // decode
  control_unit u_ctrl (
    .opcode(opcode_t'(if_id_q.instr[31:26])),
    .funct(funct_t'(if_id_q.instr[5:0])),
    .ctrl(id_ctrl)
  );

  register_file u_rf (
    .CLK, .nRST, .wen(mem_wb_q.wen), .wsel(mem_wb_q.dest), .wdat(wdat),
    .rsel1(if_id_q.instr[25:21]), .rsel2(if_id_q.instr[20:16]), .rdat1, .rdat2
  );

  always_comb begin
    case (id_ctrl.extend)
      EXT_ZERO:  imm_ext = {16'h0000, if_id_q.instr[15:0]};
      EXT_SIGN:  imm_ext = {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};
      EXT_UPPER: imm_ext = {if_id_q.instr[15:0], 16'h0000};
      default:   imm_ext = '0;
    endcase
  end

  assign jump_target = {if_id_q.pc4[31:28], if_id_q.instr[25:0], 2'b00};

  always_comb begin
    id_ex_d.ctrl = id_ctrl;
    id_ex_d.pc4 = if_id_q.pc4;
    id_ex_d.rdat1 = rdat1;
    id_ex_d.rdat2 = rdat2;
    id_ex_d.imm = imm_ext;
    id_ex_d.rs = if_id_q.instr[25:21];
    id_ex_d.rt = if_id_q.instr[20:16];
    id_ex_d.rd = if_id_q.instr[15:11];
  end

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .CLK, .nRST, .en(hif.idex_en), .flush(hif.idex_flush), .d(id_ex_d), .q(id_ex_q)
  );

  // execute
  assign operand_a = fwd_mux(fif.fwd_a, id_ex_q.rdat1, ex_mem_q.result, wdat);
  assign operand_b = fwd_mux(fif.fwd_b, id_ex_q.rdat2, ex_mem_q.result, wdat);
  assign port_b = (id_ex_q.ctrl.alu_src == SRC_IMM) ? id_ex_q.imm : operand_b;

  alu u_alu (
    .port_a(operand_a), .port_b(port_b), .alu_op(id_ex_q.ctrl.alu_op),
    .result(alu_result), .zero(alu_zero)
  );

  always_comb begin
    ex_mem_d.ctrl = id_ex_q.ctrl;
    ex_mem_d.result = alu_result;
    ex_mem_d.zero = alu_zero;
    ex_mem_d.store = fwd_mux(fif.fwd_store, id_ex_q.rdat2, ex_mem_q.result, wdat);
    ex_mem_d.br_target = id_ex_q.pc4 + (id_ex_q.imm << 2);
    ex_mem_d.dest = (id_ex_q.ctrl.reg_dst == DST_RT) ? id_ex_q.rt : id_ex_q.rd;
  end

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .CLK, .nRST, .en(hif.exmem_en), .flush(hif.exmem_flush), .d(ex_mem_d), .q(ex_mem_q)
  );

  // memory, requests drop once halted
  assign dmem_ren = ex_mem_q.ctrl.dren && !halt;
  assign dmem_wen = ex_mem_q.ctrl.dwen && !halt;
  assign dmem_addr = ex_mem_q.result;
  assign dmem_store = ex_mem_q.store;

  always_comb begin
    mem_wb_d.wen = ex_mem_q.ctrl.wen;
    mem_wb_d.wb_sel = ex_mem_q.ctrl.wb_sel;
    mem_wb_d.halt = ex_mem_q.ctrl.halt;
    mem_wb_d.result = ex_mem_q.result;
    mem_wb_d.load = dmem_load;
    mem_wb_d.dest = ex_mem_q.dest;
  end

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .CLK, .nRST, .en(hif.memwb_en), .flush(hif.memwb_flush), .d(mem_wb_d), .q(mem_wb_q)
  );

  // writeback
  assign wdat = (mem_wb_q.wb_sel == WB_MEM) ? mem_wb_q.load : mem_wb_q.result;
  assign halt = mem_wb_q.halt;

  // hazard and forwarding hookup
  assign hif.ihit = ihit;
  assign hif.dhit = dhit;
  assign hif.idex_dren = id_ex_q.ctrl.dren;
  assign hif.idex_rt = id_ex_q.rt;
  assign hif.ifid_rs = if_id_q.instr[25:21];
  assign hif.ifid_rt = if_id_q.instr[20:16];
  assign hif.ifid_jump = id_ctrl.jump;
  assign hif.exmem_taken = ex_mem_q.ctrl.branch && ex_mem_q.zero;
  assign hif.exmem_req = ex_mem_q.ctrl.dren || ex_mem_q.ctrl.dwen;
  assign hif.memwb_halt = mem_wb_q.halt;

  assign fif.idex_rs = id_ex_q.rs;
  assign fif.idex_rt = id_ex_q.rt;
  assign fif.exmem_dest = ex_mem_q.dest;
  assign fif.exmem_wen = ex_mem_q.ctrl.wen;
  assign fif.memwb_dest = mem_wb_q.dest;
  assign fif.memwb_wen = mem_wb_q.wen;

  hazard_unit  u_hazard (.hif(hif.hu));
  forward_unit u_forward (.fif(fif.fu));

endmodule

// ==== datapath_assertions.sv ====
// ======================================================================
// memory request and halt assertions, bound into datapath
// ======================================================================
module datapath_assertions import cpu_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input logic  dmem_ren,
  input logic  dmem_wen,
  input word_t dmem_addr,
  input logic  dhit,
  input logic  halt
);

  a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen)) else $error("read and write requested together");

  // request held until the hit arrives
  a_hold_request: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_ren || dmem_wen) && !dhit |=>
      $stable(dmem_ren) && $stable(dmem_wen) && $stable(dmem_addr))
    else $error("data request changed before dhit");

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt) else $error("halt fell without reset");

endmodule

bind datapath datapath_assertions u_assertions (
  .CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dhit, .halt
);

// ==== datapath_tb.sv ====
// ======================================================================
// testbench for datapath: memory models, program table, store checks
// ======================================================================
module datapath_tb import cpu_pkg::*; ();

  logic  CLK = 1'b0;
  logic  nRST;
  word_t imem_load, dmem_load, imem_addr, dmem_addr, dmem_store;
  logic  ihit, dhit, dmem_ren, dmem_wen, halt;

  word_t rom [64];
  word_t ram [256];
  word_t prog_word [$];
  bit    prog_chk [$];
  word_t prog_addr [$];
  word_t prog_data [$];
  word_t exp_addr_q [$];
  word_t exp_data_q [$];
  int    n_rows = 0;
  int    wait_left;

  datapath dut (.*);

  always #4 CLK = ~CLK;

  // instruction ROM answers the current PC
  assign imem_load = rom[imem_addr[7:2]];

  function automatic word_t enc_r(regbits_t rs, regbits_t rt, regbits_t rd, funct_t f);
    return {RTYPE, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic word_t enc_i(opcode_t op, regbits_t rs, regbits_t rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic add_row(input word_t w, input bit chk, input word_t a, input word_t d);
    prog_word.push_back(w);
    prog_chk.push_back(chk);
    prog_addr.push_back(a);
    prog_data.push_back(d);
  endtask

  task automatic build_program();
    add_row(enc_i(ADDIU, 0, 1, 16'h0005), 0, 0, 0);
    add_row(enc_i(ADDIU, 0, 2, 16'hfffd), 0, 0, 0);
    add_row(enc_i(ORI, 0, 3, 16'h8001), 0, 0, 0);
    add_row(enc_i(LUI, 0, 4, 16'h1234), 0, 0, 0);
    add_row(enc_i(SW, 0, 1, 16'h0100), 1, 32'h100, 32'h0000_0005);
    add_row(enc_i(SW, 0, 2, 16'h0104), 1, 32'h104, 32'hffff_fffd);
    add_row(enc_i(SW, 0, 3, 16'h0108), 1, 32'h108, 32'h0000_8001);
    add_row(enc_i(SW, 0, 4, 16'h010c), 1, 32'h10c, 32'h1234_0000);
    // r-type results, each stored right after it is produced
    add_row(enc_r(1, 2, 5, ADDU), 0, 0, 0);
    add_row(enc_i(SW, 0, 5, 16'h0110), 1, 32'h110, 32'h0000_0002);
    add_row(enc_r(1, 2, 6, SUBU), 0, 0, 0);
    add_row(enc_i(SW, 0, 6, 16'h0114), 1, 32'h114, 32'h0000_0008);
    add_row(enc_r(3, 2, 7, AND), 0, 0, 0);
    add_row(enc_i(SW, 0, 7, 16'h0118), 1, 32'h118, 32'h0000_8001);
    add_row(enc_r(1, 4, 8, OR), 0, 0, 0);
    add_row(enc_i(SW, 0, 8, 16'h011c), 1, 32'h11c, 32'h1234_0005);
    add_row(enc_r(2, 1, 9, SLT), 0, 0, 0);
    add_row(enc_i(SW, 0, 9, 16'h0120), 1, 32'h120, 32'h0000_0001);
    add_row(enc_r(1, 2, 10, SLT), 0, 0, 0);
    add_row(enc_i(SW, 0, 10, 16'h0124), 1, 32'h124, 32'h0000_0000);
    // dependent chain, EX/MEM and MEM/WB forwarding
    add_row(enc_i(ADDIU, 0, 11, 16'd10), 0, 0, 0);
    add_row(enc_r(11, 11, 12, ADDU), 0, 0, 0);
    add_row(enc_r(12, 11, 13, ADDU), 0, 0, 0);
    add_row(enc_i(SW, 0, 13, 16'h0128), 1, 32'h128, 32'd30);
    add_row(enc_i(SW, 0, 12, 16'h012c), 1, 32'h12c, 32'd20);
    // load-use pairs
    add_row(enc_i(LW, 0, 14, 16'h0100), 0, 0, 0);
    add_row(enc_i(ADDIU, 14, 15, 16'd100), 0, 0, 0);
    add_row(enc_i(SW, 0, 15, 16'h0130), 1, 32'h130, 32'd105);
    add_row(enc_i(LW, 0, 16, 16'h0040), 0, 0, 0);
    add_row(enc_r(16, 1, 17, ADDU), 0, 0, 0);
    add_row(enc_i(SW, 0, 17, 16'h0134), 1, 32'h134, 32'hc010_ef15);
    // taken beq skips two planted stores
    add_row(enc_i(BEQ, 1, 14, 16'd2), 0, 0, 0);
    add_row(enc_i(SW, 0, 2, 16'h01f0), 0, 0, 0);
    add_row(enc_i(SW, 0, 3, 16'h01f4), 0, 0, 0);
    add_row(enc_i(BEQ, 1, 2, 16'd1), 0, 0, 0);
    add_row(enc_i(SW, 0, 7, 16'h013c), 1, 32'h13c, 32'h0000_8001);
    add_row({J, 26'd38}, 0, 0, 0);
    add_row(enc_i(SW, 0, 8, 16'h01f8), 0, 0, 0);
    add_row(enc_i(SW, 0, 9, 16'h0140), 1, 32'h140, 32'h0000_0001);
    add_row({HALT, 26'd0}, 0, 0, 0);
    add_row(enc_i(SW, 0, 1, 16'h01fc), 0, 0, 0);
  endtask

  // data RAM with random dhit latency, stores checked at dhit
  always @(posedge CLK) begin
    if (nRST) begin
      if (dhit) begin
        dhit <= 1'b0;
        if (dmem_wen) begin
          if (exp_addr_q.size() == 0) begin
            fail_run($sformatf("store to %h after the last expected store", dmem_addr));
          end else begin
            assert (dmem_addr == exp_addr_q[0] && dmem_store == exp_data_q[0]) else
              fail_run($sformatf("error at %0t: store %h to %h, expected %h to %h",
                                 $time, dmem_store, dmem_addr, exp_data_q[0],
                                 exp_addr_q[0]));
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
          end
          ram[dmem_addr[9:2]] = dmem_store;
        end
      end else if (dmem_ren || dmem_wen) begin
        if (wait_left == 0) begin
          dhit <= 1'b1;
          dmem_load <= ram[dmem_addr[9:2]];
          wait_left <= int'($urandom_range(3));
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

  // one fetch in four misses
  always @(posedge CLK) begin
    ihit <= nRST ? ($urandom_range(3) != 0) : 1'b1;
  end

  initial begin
    wait (n_rows > 0);
    repeat (n_rows * 40) @(posedge CLK);
    fail_run("timeout: the core never reached halt");
  end

  initial begin
    logic [7:0] idx;
    void'($urandom(68));
    nRST = 1'b0;
    ihit = 1'b1;
    dhit = 1'b0;
    dmem_load = '0;
    wait_left = 0;
    build_program();
    foreach (rom[i]) rom[i] = NOP_WORD;
    for (int i = 0; i < prog_word.size(); i++) begin
      rom[i] = prog_word[i];
      if (prog_chk[i]) begin
        exp_addr_q.push_back(prog_addr[i]);
        exp_data_q.push_back(prog_data[i]);
      end
    end
    for (int i = 0; i < 256; i++) begin
      idx = i[7:0];
      ram[i] = {8'hc0, idx, ~idx, idx};
    end
    n_rows = prog_word.size();
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    wait (halt === 1'b1);
    // let any late write show up
    repeat (20) @(posedge CLK);
    if (exp_addr_q.size() == 0 && halt === 1'b1) begin
      $display("Regression passed");
      $finish;
    end else if (halt !== 1'b1) begin
      fail_run("halt fell after it was raised");
    end else begin
      fail_run($sformatf("%0d expected stores never happened", exp_addr_q.size()));
    end
  end

endmodule

// ==== all.f ====
cpu_pkg.sv
cpu_ifs.sv
alu.sv
register_file.sv
control_unit.sv
pipe_reg.sv
forward_unit.sv
hazard_unit.sv
datapath.sv
datapath_assertions.sv
datapath_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = datapath_tb
FILELIST = all.f
LOG      = sim.log

.PHONY: all run lint clean

all: run

run:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)
	! grep -q "Regression failed" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
